/* project.f */
verilog/vdg_timing_pkg.sv
verilog/vdg_mode_pkg.sv
verilog/vdg_raster.sv
verilog/vdg_pixel.sv
verilog/vdg_colour_out.sv
verilog/vdg.sv
tests/tb_vdg.sv

/* run.sh */
#!/bin/sh
# build the vdg testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_vdg -o tb_vdg
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_vdg)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
   exit 0
fi
exit 1

/* tests/tb_vdg.sv */
`timescale 1ns/1ns

module tb_vdg;
   import vdg_timing_pkg::*;
   import vdg_mode_pkg::*;

   localparam int LINE_PIXELS    = 402;
   localparam int FIELD_LINES    = 262;
   localparam int FIELD_CYCLES   = 2 * LINE_PIXELS * FIELD_LINES;
   localparam int TIMEOUT_CYCLES = 4 * FIELD_CYCLES;   // the tests end early in the fourth field
   localparam int HSYNC_BIT      = 0;
   localparam int VSYNC_BIT      = 1;
   localparam int HBLANK_BIT     = 2;
   localparam int VBLANK_BIT     = 3;

   logic              clk;
   logic              reset;
   logic              clk_ena_i;
   logic [7:0]        dd_i;
   mode_sel_t         mode_i;
   logic [ADDR_W-1:0] videoaddr_o;
   logic              hs_n_o;
   logic              fs_n_o;
   raster_t           sync_o;
   rgb_t              rgb_o;

   raster_t     cur;         // sync_o at the latest pixel sample
   raster_t     prev;
   logic        cur_hs_n;
   logic        prev_hs_n;
   logic        cur_fs_n;
   logic [16:0] lfsr_state;
   rgb_t        allowed[$];  // colours legal on the line being scanned
   int          cycle_count;
   int          checks;
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;

   vdg vdg_inst (
      .clk         (clk),
      .reset       (reset),
      .clk_ena_i   (clk_ena_i),
      .dd_i        (dd_i),
      .mode_i      (mode_i),
      .videoaddr_o (videoaddr_o),
      .hs_n_o      (hs_n_o),
      .fs_n_o      (fs_n_o),
      .sync_o      (sync_o),
      .rgb_o       (rgb_o)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   // x^17 + x^14 + 1
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic random_byte(output logic [7:0] b);
      b = 8'h00;
      for (int i = 0; i < 8; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         b = {b[6:0], lfsr_state[0]};
      end
   endtask

   function automatic rgb_t levels(input logic r, input logic g, input logic b);
      return '{red: r ? COLOUR_HI : 8'h00, green: g ? COLOUR_HI : 8'h00,
               blue: b ? COLOUR_HI : 8'h00};
   endfunction

   // palette for luma 1
   function automatic rgb_t colour_for(input logic [2:0] chroma);
      case (chroma)
         3'd0:    return levels(1'b0, 1'b1, 1'b0);   // green
         3'd1:    return levels(1'b1, 1'b1, 1'b0);   // yellow
         3'd2:    return levels(1'b0, 1'b0, 1'b1);   // blue
         3'd3:    return levels(1'b1, 1'b0, 1'b0);   // red
         3'd4:    return levels(1'b1, 1'b1, 1'b1);   // buff
         3'd5:    return levels(1'b0, 1'b1, 1'b1);   // cyan
         3'd6:    return levels(1'b1, 1'b0, 1'b1);   // magenta
         default: return levels(1'b1, 1'b1, 1'b0);   // orange
      endcase
   endfunction

   function automatic mode_sel_t mode_pins(input logic an_g, input logic intn_ext,
                                           input logic css, input mode_t gm);
      return '{an_g: an_g, intn_ext: intn_ext, css: css, gm: gm};
   endfunction

   function automatic logic sync_bit(input raster_t r, input int idx);
      case (idx)
         HSYNC_BIT:  return r.hsync;
         VSYNC_BIT:  return r.vsync;
         HBLANK_BIT: return r.hblank;
         default:    return r.vblank;
      endcase
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
      checks++;
      if (got !== exp)
      begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp)
      begin
         $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      checks++;
      test_errors++;
      $display("%0t: %s", $time, msg);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("%0t test %0d %s: passed", $time, tests_run, name);
      else
      begin
         $display("%0t test %0d %s: failed with %0d errors", $time, tests_run, name,
                  test_errors);
         tests_failed++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   task automatic drive_inputs(input mode_sel_t m, input logic [7:0] d);
      @(posedge clk);
      #2;
      mode_i = m;
      dd_i   = d;
   endtask

   // one sample per pixel, taken where sync_o and rgb_o are stable
   task automatic next_pixel;
      prev      = cur;
      prev_hs_n = cur_hs_n;
      @(negedge clk);
      while (!sync_o.pix_en)
         @(negedge clk);
      cur      = sync_o;
      cur_hs_n = hs_n_o;
      cur_fs_n = fs_n_o;
   endtask

   task automatic wait_fall(input int idx);
      next_pixel();
      while (!(sync_bit(prev, idx) && !sync_bit(cur, idx)))
         next_pixel();
   endtask

   // from a falling edge up to the rising edge
   task automatic count_low(input int idx, output int n);
      n = 1;
      next_pixel();
      while (!sync_bit(cur, idx))
      begin
         n++;
         next_pixel();
      end
   endtask

   // from a falling edge up to the next falling edge
   task automatic count_period(input int idx, output int n);
      n = 0;
      do
      begin
         next_pixel();
         n++;
      end
      while (!(sync_bit(prev, idx) && !sync_bit(cur, idx)));
   endtask

   task automatic wait_active_line;
      wait_fall(HSYNC_BIT);
      while (cur.vblank)
         wait_fall(HSYNC_BIT);
   endtask

   task automatic check_line_addresses(input logic [ADDR_W-1:0] base, input int width);
      logic [31:0] seen;
      int          off;
      logic        first;
      seen  = '0;
      first = 1'b1;
      repeat (LINE_PIXELS)
      begin
         next_pixel();
         if (!cur.hblank && !cur.vblank)
         begin
            if (first)
               check_addr("first videoaddr_o of line", videoaddr_o, base);
            first = 1'b0;
            off   = int'(videoaddr_o) - int'(base);
            if (off < 0 || off >= width)
               report_failure($sformatf("videoaddr_o %h lies outside the line at base %h",
                                        videoaddr_o, base));
            else
               seen[off] = 1'b1;
         end
      end
      check_count("distinct addresses on line", $countones(seen), width);
   endtask

   task automatic scan_line_colours(output logic [3:0] seen);
      int idx;
      seen = '0;
      repeat (LINE_PIXELS - 2)
      begin
         next_pixel();
         if (cur.hblank || cur.vblank)
            check_rgb("rgb_o in blanking", rgb_o, '0);
         else if (allowed.size() == 1)
         begin
            check_rgb("rgb_o", rgb_o, allowed[0]);
            seen[0] = 1'b1;
         end
         else
         begin
            idx = -1;
            foreach (allowed[i])
               if (rgb_o == allowed[i])
                  idx = i;
            if (idx < 0)
               report_failure($sformatf("rgb_o %h is not a colour allowed on this line",
                                        rgb_o));
            else
               seen[idx] = 1'b1;
         end
      end
   endtask

   task automatic test_line_timing;
      int n;
      wait_fall(HSYNC_BIT);
      count_low(HSYNC_BIT, n);
      check_count("hsync low pixels", n, 48);
      wait_fall(HSYNC_BIT);
      count_period(HSYNC_BIT, n);
      check_count("line length pixels", n, LINE_PIXELS);
      wait_fall(HBLANK_BIT);
      count_low(HBLANK_BIT, n);
      check_count("hblank low pixels", n, 258);
      end_test("line timing");
   endtask

   task automatic test_field_timing;
      int n;
      wait_fall(VBLANK_BIT);
      check_bit("fs_n_o in active video", cur_fs_n, 1'b1);
      count_low(VBLANK_BIT, n);
      check_count("vblank low pixels", n, 192 * LINE_PIXELS);
      check_bit("fs_n_o after last active line", cur_fs_n, 1'b0);
      wait_fall(VSYNC_BIT);
      count_period(VSYNC_BIT, n);
      check_count("field length pixels", n, FIELD_LINES * LINE_PIXELS);
      count_low(VSYNC_BIT, n);
      check_count("vsync low pixels", n, 2 * LINE_PIXELS);
      // hs_n_o leads sync_o by one pixel
      repeat (LINE_PIXELS)
      begin
         next_pixel();
         check_bit("hs_n_o", prev_hs_n, ~cur.hblank);
      end
      end_test("field timing");
   endtask

   task automatic test_rg6_addressing;
      drive_inputs(mode_pins(1'b1, 1'b0, 1'b0, RG6), 8'h00);
      wait_fall(VBLANK_BIT);
      for (int k = 0; k < 4; k++)
         check_line_addresses(ADDR_W'(32 * k), 32);
      end_test("RG6 addressing");
   endtask

   task automatic test_cg1_addressing;
      drive_inputs(mode_pins(1'b1, 1'b0, 1'b0, CG1), 8'h00);
      wait_fall(VBLANK_BIT);
      for (int k = 0; k < 7; k++)
         check_line_addresses(ADDR_W'(16 * (k / 3)), 16);
      end_test("CG1 addressing");
   endtask

   task automatic test_graphics_colour;
      logic [3:0] seen;
      drive_inputs(mode_pins(1'b1, 1'b0, 1'b0, RG6), 8'hFF);
      wait_active_line();
      allowed.delete();
      allowed.push_back(colour_for(3'd0));
      scan_line_colours(seen);
      drive_inputs(mode_pins(1'b1, 1'b0, 1'b1, RG6), 8'hFF);
      wait_active_line();
      allowed.delete();
      allowed.push_back(colour_for(3'd4));
      scan_line_colours(seen);
      // 8'h1b holds the pairs 00 01 10 11
      drive_inputs(mode_pins(1'b1, 1'b0, 1'b0, CG6), 8'h1B);
      wait_active_line();
      allowed.delete();
      for (int c = 0; c < 4; c++)
         allowed.push_back(colour_for(3'(c)));
      scan_line_colours(seen);
      check_count("CG6 colours shown", $countones(seen), 4);
      end_test("graphics colour");
   endtask

   task automatic test_semigraphics_colour;
      logic [7:0] data;
      logic [3:0] seen;
      repeat (6)
      begin
         random_byte(data);
         drive_inputs(mode_pins(1'b0, 1'b0, 1'b0, CG1), data);
         wait_active_line();
         allowed.delete();
         allowed.push_back('0);
         allowed.push_back(colour_for(data[6:4]));
         scan_line_colours(seen);
         // no lit quadrant means black only, lit quadrants in both halves show on any row
         if (seen[1] && data[3:0] == 4'h0)
            report_failure($sformatf("block colour shown for byte %h with no lit quadrant",
                                     data));
         if (!seen[1] && data[3:2] != 2'b00 && data[1:0] != 2'b00)
            report_failure($sformatf("block colour missing for byte %h with lit quadrants",
                                     data));
      end
      end_test("semigraphics colour");
   endtask

   initial
   begin
      clk          = 1'b0;
      reset        = 1'b1;
      clk_ena_i    = 1'b1;
      dd_i         = 8'h00;
      mode_i       = mode_pins(1'b1, 1'b0, 1'b0, RG6);
      lfsr_state   = 17'd71309;
      cur          = '0;
      prev         = '0;
      cur_hs_n     = 1'b0;
      prev_hs_n    = 1'b0;
      cur_fs_n     = 1'b0;
      cycle_count  = 0;
      checks       = 0;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      test_line_timing();
      test_field_timing();
      test_rg6_addressing();
      test_cg1_addressing();
      test_graphics_colour();
      test_semigraphics_colour();
      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
               checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

/* verilog/vdg.sv */
`timescale 1ns/1ns

module vdg (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              clk_ena_i,
   input  logic [7:0]                        dd_i,
   input  vdg_mode_pkg::mode_sel_t           mode_i,
   output logic [vdg_timing_pkg::ADDR_W-1:0] videoaddr_o,
   output logic                              hs_n_o,
   output logic                              fs_n_o,
   output vdg_timing_pkg::raster_t           sync_o,
   output vdg_mode_pkg::rgb_t                rgb_o
);
   import vdg_timing_pkg::*;
   import vdg_mode_pkg::*;

   raster_t    raster;
   logic       active_start;
   logic [3:0] row;
   pixel_t     pix;

   // counters, syncs and the memory address
   vdg_raster raster_inst (
      .clk            (clk),
      .reset          (reset),
      .clk_ena_i      (clk_ena_i),
      .mode_i         (mode_i),
      .raster_o       (raster),
      .active_start_o (active_start),
      .row_o          (row),
      .videoaddr_o    (videoaddr_o),
      .hs_n_o         (hs_n_o),
      .fs_n_o         (fs_n_o)
   );

   vdg_pixel pixel_inst (
      .clk            (clk),
      .reset          (reset),
      .raster_i       (raster),
      .active_start_i (active_start),
      .row_i          (row),
      .mode_i         (mode_i),
      .dd_i           (dd_i),
      .pix_o          (pix)
   );

   vdg_colour_out colour_out_inst (
      .clk      (clk),
      .reset    (reset),
      .raster_i (raster),
      .pix_i    (pix),
      .sync_o   (sync_o),
      .rgb_o    (rgb_o)
   );

endmodule

/* verilog/vdg_colour_out.sv */
`timescale 1ns/1ns

module vdg_colour_out (
   input  logic                    clk,
   input  logic                    reset,
   input  vdg_timing_pkg::raster_t raster_i,
   input  vdg_mode_pkg::pixel_t    pix_i,
   output vdg_timing_pkg::raster_t sync_o,
   output vdg_mode_pkg::rgb_t      rgb_o
);
   import vdg_mode_pkg::*;

   logic [2:0] chan_on;   // r, g, b
   rgb_t       colour;

   always_comb
   begin
      chan_on = 3'b000;
      if (pix_i.luma)
      begin
         case (pix_i.chroma)
            3'd0: chan_on = 3'b010;   // green
            3'd1: chan_on = 3'b110;   // yellow
            3'd2: chan_on = 3'b001;   // blue
            3'd3: chan_on = 3'b100;   // red
            3'd4: chan_on = 3'b111;   // buff
            3'd5: chan_on = 3'b011;   // cyan
            3'd6: chan_on = 3'b101;   // magenta
            3'd7: chan_on = 3'b110;   // orange
         endcase
      end
      colour.red   = chan_on[2] ? COLOUR_HI : 8'h00;
      colour.green = chan_on[1] ? COLOUR_HI : 8'h00;
      colour.blue  = chan_on[0] ? COLOUR_HI : 8'h00;
   end

   // syncs and colour leave together
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         sync_o <= '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b0, vblank: 1'b1, pix_en: 1'b0};
         rgb_o  <= '0;
      end
      else
      begin
         sync_o.pix_en <= raster_i.pix_en;   // marks a new pixel
         if (raster_i.pix_en)
         begin
            sync_o.hsync  <= raster_i.hsync;
            sync_o.vsync  <= raster_i.vsync;
            sync_o.hblank <= raster_i.hblank;
            sync_o.vblank <= raster_i.vblank;
            if (raster_i.hblank || raster_i.vblank)
               rgb_o <= '0;
            else
               rgb_o <= colour;
         end
      end
   end

endmodule

/* verilog/vdg_mode_pkg.sv */
package vdg_mode_pkg;

   // gm pin codes
   typedef enum logic [2:0] {
      CG1 = 3'd0,
      RG1 = 3'd1,
      CG2 = 3'd2,
      RG2 = 3'd3,
      CG3 = 3'd4,
      RG3 = 3'd5,
      CG6 = 3'd6,
      RG6 = 3'd7
   } mode_t;

   // mode pins as sampled by the core
   typedef struct packed {
      logic  an_g;       // low selects semigraphics
      logic  intn_ext;   // semi-4 when low, semi-6 when high
      logic  css;
      mode_t gm;
   } mode_sel_t;

   typedef struct packed {
      logic       luma;
      logic [2:0] chroma;
   } pixel_t;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   // level of an active palette channel
   localparam logic [7:0] COLOUR_HI = 8'hC0;

   // graphics modes fetching 16 bytes per line, everything else uses 32
   function automatic logic row_is_16_bytes(input mode_sel_t mode);
      return mode.an_g && (mode.gm inside {CG1, RG1, RG2, RG3});
   endfunction

endpackage

/* verilog/vdg_pixel.sv */
`timescale 1ns/1ns

module vdg_pixel (
   input  logic                    clk,
   input  logic                    reset,
   input  vdg_timing_pkg::raster_t raster_i,
   input  logic                    active_start_i,
   input  logic [3:0]              row_i,
   input  vdg_mode_pkg::mode_sel_t mode_i,
   input  logic [7:0]              dd_i,
   output vdg_mode_pkg::pixel_t    pix_o
);
   import vdg_mode_pkg::*;

   logic [3:0] count;
   logic [3:0] cnt_cur;
   logic [7:0] dd_r;
   logic [7:0] semi_byte;
   logic       narrow;
   pixel_t     pix_next;

   assign cnt_cur = active_start_i ? 4'd0 : count;   // restart at the left border
   assign narrow  = row_is_16_bytes(mode_i);

   // semigraphics byte as two luma/chroma nibbles for this row
   always_comb
   begin
      if (!mode_i.intn_ext)
      begin
         // semi-4, 2x2 blocks
         if (row_i < 4'd6)
            semi_byte = {dd_i[3], dd_i[6:4], dd_i[2], dd_i[6:4]};
         else
            semi_byte = {dd_i[1], dd_i[6:4], dd_i[0], dd_i[6:4]};
      end
      else
      begin
         // semi-6, 2x3 blocks
         if (row_i < 4'd4)
            semi_byte = {dd_i[5], mode_i.css, dd_i[7:6], dd_i[4], mode_i.css, dd_i[7:6]};
         else if (row_i < 4'd8)
            semi_byte = {dd_i[3], mode_i.css, dd_i[7:6], dd_i[2], mode_i.css, dd_i[7:6]};
         else
            semi_byte = {dd_i[1], mode_i.css, dd_i[7:6], dd_i[0], mode_i.css, dd_i[7:6]};
      end
   end

   // latch and shift
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         count <= 4'd0;
         dd_r  <= 8'd0;
      end
      else if (raster_i.pix_en)
      begin
         count <= cnt_cur + 4'd1;
         if (!mode_i.an_g)
         begin
            if (cnt_cur[2:0] == 3'd0)
               dd_r <= semi_byte;
            else if (cnt_cur[1:0] == 2'd0)
               dd_r <= {dd_r[3:0], 4'b0000};   // second half of the character
         end
         else if (narrow)
         begin
            // one byte per 16 pixels
            if (cnt_cur == 4'd0)
               dd_r <= dd_i;
            else if (mode_i.gm == CG1)
            begin
               if (cnt_cur[1:0] == 2'd0)
                  dd_r <= {dd_r[5:0], 2'b00};
            end
            else if (!cnt_cur[0])
               dd_r <= {dd_r[6:0], 1'b0};
         end
         else
         begin
            if (cnt_cur[2:0] == 3'd0)
               dd_r <= dd_i;
            else if (mode_i.gm == RG6)
               dd_r <= {dd_r[6:0], 1'b0};   // one bit per pixel
            else if (!cnt_cur[0])
               dd_r <= {dd_r[5:0], 2'b00};  // CG2, CG3, CG6
         end
      end
   end

   always_comb
   begin
      if (!mode_i.an_g)
         pix_next = '{luma: dd_r[7], chroma: dd_r[6:4]};
      else
      begin
         case (mode_i.gm)
            CG1, CG2, CG3, CG6: pix_next = '{luma: 1'b1, chroma: {mode_i.css, dd_r[7:6]}};
            default:            pix_next = '{luma: dd_r[7], chroma: {mode_i.css, 2'b00}};
         endcase
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pix_o <= '0;
      else if (raster_i.pix_en)
         pix_o <= pix_next;
   end

endmodule

/* verilog/vdg_raster.sv */
`timescale 1ns/1ns

module vdg_raster (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              clk_ena_i,
   input  vdg_mode_pkg::mode_sel_t           mode_i,
   output vdg_timing_pkg::raster_t           raster_o,
   output logic                              active_start_o,
   output logic [3:0]                        row_o,
   output logic [vdg_timing_pkg::ADDR_W-1:0] videoaddr_o,
   output logic                              hs_n_o,
   output logic                              fs_n_o
);
   import vdg_timing_pkg::*;
   import vdg_mode_pkg::*;

   logic              toggle;
   logic              pix_en;
   logic [8:0]        h_count;
   logic [8:0]        v_count;
   logic [8:0]        h_next;
   logic [8:0]        v_next;
   logic              line_end;
   logic              hsync;
   logic              vsync;
   logic              hblank;
   logic              vblank;
   logic              fs_int;
   logic [3:0]        row;
   logic [1:0]        triplet;
   logic [ADDR_W-1:0] base;
   logic [ADDR_W-1:0] base_step;
   logic [7:0]        active_cnt;
   logic [7:0]        pix_pos;
   logic [4:0]        lookup;
   logic              narrow;

   // pixel enable at half the clock enable rate
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         toggle <= 1'b0;
         pix_en <= 1'b0;
      end
      else
      begin
         pix_en <= clk_ena_i & toggle;
         if (clk_ena_i)
            toggle <= ~toggle;
      end
   end

   assign line_end = (h_count == H_TOTAL_PER_LINE);

   always_comb
   begin
      h_next = line_end ? 9'd0 : h_count + 9'd1;
      if (!line_end)
         v_next = v_count;
      else if (v_count == V_TOTAL_PER_FIELD)
         v_next = 9'd0;
      else
         v_next = v_count + 9'd1;
   end

   // horizontal sync, blank and the address count
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         h_count        <= 9'(H_TOTAL_PER_LINE);
         hsync          <= 1'b1;
         hblank         <= 1'b0;
         active_start_o <= 1'b0;
         active_cnt     <= 8'd0;
      end
      else if (pix_en)
      begin
         h_count        <= h_next;
         active_start_o <= (h_next == H_LEFT_BORDER);
         if (h_next == H_FRONT_PORCH)
            hsync <= 1'b0;
         else if (h_next == H_HORIZ_SYNC)
            hsync <= 1'b1;
         if (h_next == H_LEFT_BORDER)
            hblank <= 1'b0;
         else if (h_next == H_VIDEO)
            hblank <= 1'b1;
         if (h_next == H_LEFT_RSTADDR)
            active_cnt <= 8'd0;
         else if (h_next >= H_BACK_PORCH)   // idle through sync
            active_cnt <= active_cnt + 8'd1;
      end
   end

   // base step at a line end, per mode
   always_comb
   begin
      base_step = '0;
      if (!mode_i.an_g)
      begin
         if (row == 4'd11)
            base_step = ADDR_W'(32);   // one semigraphics character row
      end
      else
      begin
         case (mode_i.gm)
            CG1, RG1: if (triplet == 2'd2) base_step = ADDR_W'(16);
            CG2:      if (triplet == 2'd2) base_step = ADDR_W'(32);
            RG2:      if (row[0]) base_step = ADDR_W'(16);
            CG3:      if (row[0]) base_step = ADDR_W'(32);
            RG3:      base_step = ADDR_W'(16);
            default:  base_step = ADDR_W'(32);   // CG6, RG6
         endcase
      end
   end

   // vertical sync, blank, field sync and the line base
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         v_count <= 9'(V_TOTAL_PER_FIELD);
         vsync   <= 1'b1;
         vblank  <= 1'b1;
         fs_int  <= 1'b0;
         row     <= 4'd0;
         triplet <= 2'd0;
         base    <= '0;
      end
      else if (pix_en && line_end)
      begin
         v_count <= v_next;
         if (v_next == V_FRONT_PORCH)
            vsync <= 1'b0;
         else if (v_next == V_VERTICAL_SYNC)
            vsync <= 1'b1;
         if (v_next == V_TOP_BORDER)
            vblank <= 1'b0;
         else if (v_next == V_VIDEO)
            vblank <= 1'b1;
         if (v_next == V_VIDEO)
            fs_int <= 1'b1;
         else if (v_next == V_VERTICAL_SYNC)
            fs_int <= 1'b0;
         if (v_next == V_TOP_BORDER)
         begin
            // first displayed line
            base    <= '0;
            row     <= 4'd0;
            triplet <= 2'd0;
         end
         else if (v_next > V_BACK_PORCH)
         begin
            base    <= base + base_step;
            row     <= (row == 4'd11) ? 4'd0 : row + 4'd1;
            triplet <= (triplet == 2'd2) ? 2'd0 : triplet + 2'd1;
         end
      end
   end

   // byte position, lined up two pixels ahead of the border
   assign pix_pos = active_cnt - 8'(H_LEFT_BORDER - H_LEFT_RSTADDR - 2);
   assign narrow  = row_is_16_bytes(mode_i);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         lookup      <= 5'd0;
         videoaddr_o <= '0;
      end
      else if (pix_en)
      begin
         lookup <= narrow ? {1'b0, pix_pos[7:4]} : pix_pos[7:3];
         if (narrow)
            videoaddr_o <= {base[ADDR_W-1:4], lookup[3:0]};
         else
            videoaddr_o <= {base[ADDR_W-1:5], lookup};
      end
   end

   assign raster_o = '{hsync: hsync, vsync: vsync, hblank: hblank,
                       vblank: vblank, pix_en: pix_en};
   assign row_o    = row;
   assign hs_n_o   = ~hblank;
   assign fs_n_o   = ~fs_int;

endmodule

/* verilog/vdg_timing_pkg.sv */
package vdg_timing_pkg;

   // horizontal events, in pixel enables from the start of a line
   localparam int H_FRONT_PORCH    = 8;
   localparam int H_HORIZ_SYNC     = H_FRONT_PORCH + 48;
   localparam int H_BACK_PORCH     = H_HORIZ_SYNC + 24;
   localparam int H_LEFT_BORDER    = H_BACK_PORCH + 34;
   localparam int H_LEFT_RSTADDR   = H_LEFT_BORDER - 16;   // address count restart
   localparam int H_VIDEO          = H_LEFT_BORDER + 258;
   localparam int H_TOTAL_PER_LINE = H_VIDEO + 29;         // last count, 402 per line

   // vertical events, in lines from the start of a field
   localparam int V_FRONT_PORCH     = 2;
   localparam int V_VERTICAL_SYNC   = V_FRONT_PORCH + 2;
   localparam int V_BACK_PORCH      = V_VERTICAL_SYNC + 12;
   localparam int V_TOP_BORDER      = V_BACK_PORCH + 26;
   localparam int V_VIDEO           = V_TOP_BORDER + 192;
   localparam int V_TOTAL_PER_FIELD = V_VIDEO + 27;        // last count, 262 per field

   // video memory address width
   localparam int ADDR_W = 13;

   // raster state shared by the pixel path and the output stage
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic hblank;
      logic vblank;
      logic pix_en;   // one clk per pixel
   } raster_t;

endpackage
